// ==== verilog/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  byte_en_t;

	localparam word_t     RESET_PC = 32'h0000_0000;
	localparam reg_addr_t LINK_REG = 5'd31;
	localparam word_t     NOP_WORD = 32'h0000_0000; // sll r0,r0,0

	////////////////////////////////////////////////////////////
	// opcode field, inst[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LB      = 6'h20;
	localparam logic [5:0] OP_LH      = 6'h21;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_LBU     = 6'h24;
	localparam logic [5:0] OP_LHU     = 6'h25;
	localparam logic [5:0] OP_SB      = 6'h28;
	localparam logic [5:0] OP_SH      = 6'h29;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// funct field of OP_SPECIAL, inst[5:0]
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} mem_size_e;
	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_e;

	////////////////////////////////////////////////////////////
	// pipeline registers
	typedef struct packed {
		alu_op_e     alu_op;
		logic        use_imm;
		logic [15:0] imm;
		logic        sign_ext;
		logic [4:0]  shamt;
		logic        lui;
		word_t       rs_val;
		word_t       rt_val;
		word_t       link;     // pc+8
		wb_sel_e     wb_sel;
		reg_addr_t   st_reg;   // rt index, for store data forwarding
		reg_addr_t   dest;
		logic        we;
		logic        load;
		logic        store;
		mem_size_e   size;
		logic        ld_signed;
	} id_ex_t;

	typedef struct packed {
		word_t     result;     // address for loads and stores
		word_t     st_data;
		reg_addr_t st_reg;
		reg_addr_t dest;
		logic      we;
		logic      load;
		logic      store;
		mem_size_e size;
		logic      ld_signed;
	} ex_mem_t;

	typedef struct packed {
		logic      we;
		reg_addr_t dest;
		word_t     data;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== verilog/bypass_if.sv ====
`default_nettype none

// results still in flight, seen by the forwarding logic
interface bypass_if import mips_pkg::*; ();
	reg_addr_t ex_dest;
	logic      ex_we;
	logic      ex_load;
	word_t     ex_result;  // address when ex_load is set

	reg_addr_t mem_dest;
	logic      mem_we;
	word_t     mem_data;   // final writeback value

	modport ex_src (output ex_dest, ex_we, ex_load, ex_result);
	modport mem_src (output mem_dest, mem_we, mem_data);
	modport hazard (input ex_dest, ex_we, ex_load, ex_result, mem_dest, mem_we, mem_data);
endinterface

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
`default_nettype none

module fetch_unit import mips_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  stall,
	input  wire logic  redirect,
	input  wire word_t redirect_pc,
	input  wire word_t inst_data,
	output word_t      inst_addr,
	output word_t      if_inst,
	output word_t      if_pc
);

	word_t pc;

	assign inst_addr = pc;

	// redirect arrives while the delay slot is being fetched
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= RESET_PC;
			if_inst <= NOP_WORD;  // bubble
			if_pc   <= RESET_PC;
		end else if (!stall) begin
			pc      <= redirect ? redirect_pc : pc + 32'd4;
			if_inst <= inst_data;
			if_pc   <= pc;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`default_nettype none

module decode_stage import mips_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire word_t   if_inst,
	input  wire word_t   if_pc,
	input  wire logic    stall,
	input  wire word_t   rs_val,
	input  wire word_t   rt_val,
	input  wire mem_wb_t mem_wb,
	output reg_addr_t    rs_addr,
	output reg_addr_t    rt_addr,
	output word_t        rs_raw,
	output word_t        rt_raw,
	output logic         redirect,
	output word_t        redirect_pc,
	output id_ex_t       id_ex
);

	logic [5:0] opcode, funct;
	reg_addr_t  rd_addr;
	word_t      regs [32];
	word_t      pc_plus4;
	logic       is_beq, is_bne, is_jump, is_jr;
	id_ex_t     id_d;

	assign opcode   = if_inst[31:26];
	assign funct    = if_inst[5:0];
	assign rs_addr  = if_inst[25:21];
	assign rt_addr  = if_inst[20:16];
	assign rd_addr  = if_inst[15:11];
	assign pc_plus4 = if_pc + 32'd4;

	////////////////////////////////////////////////////////////
	// register file, written from WB
	always_ff @(posedge clk) begin
		if (mem_wb.we && mem_wb.dest != '0)
			regs[mem_wb.dest] <= mem_wb.data;
	end

	// r0 is hard zero, WB data bypasses the array
	assign rs_raw = (rs_addr == '0) ? '0 :
		(mem_wb.we && mem_wb.dest == rs_addr) ? mem_wb.data : regs[rs_addr];
	assign rt_raw = (rt_addr == '0) ? '0 :
		(mem_wb.we && mem_wb.dest == rt_addr) ? mem_wb.data : regs[rt_addr];

	////////////////////////////////////////////////////////////
	// control decode
	always_comb begin
		id_d = '0;
		id_d.alu_op = ALU_ADD;
		id_d.imm    = if_inst[15:0];
		id_d.shamt  = if_inst[10:6];
		id_d.rs_val = rs_val;
		id_d.rt_val = rt_val;
		id_d.link   = if_pc + 32'd8;
		id_d.wb_sel = WB_ALU;
		id_d.st_reg = rt_addr;
		id_d.dest   = rt_addr;  // i-type default
		id_d.size   = SZ_WORD;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_jump = 1'b0;
		is_jr = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				id_d.dest = rd_addr;
				id_d.we   = 1'b1;
				case (funct)
					FN_ADDU: id_d.alu_op = ALU_ADD;
					FN_SUBU: id_d.alu_op = ALU_SUB;
					FN_AND:  id_d.alu_op = ALU_AND;
					FN_OR:   id_d.alu_op = ALU_OR;
					FN_XOR:  id_d.alu_op = ALU_XOR;
					FN_NOR:  id_d.alu_op = ALU_NOR;
					FN_SLT:  id_d.alu_op = ALU_SLT;
					FN_SLTU: id_d.alu_op = ALU_SLTU;
					FN_SLL:  id_d.alu_op = ALU_SLL;
					FN_SRL:  id_d.alu_op = ALU_SRL;
					FN_SRA:  id_d.alu_op = ALU_SRA;
					FN_JR: begin
						id_d.we = 1'b0;
						is_jr   = 1'b1;
					end
					default: id_d.we = 1'b0;  // unknown funct is a nop
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
				id_d.we       = 1'b1;
				id_d.use_imm  = 1'b1;
				id_d.sign_ext = opcode inside {OP_ADDIU, OP_SLTI, OP_SLTIU};
				case (opcode)
					OP_SLTI:  id_d.alu_op = ALU_SLT;
					OP_SLTIU: id_d.alu_op = ALU_SLTU;
					OP_ANDI:  id_d.alu_op = ALU_AND;
					OP_ORI:   id_d.alu_op = ALU_OR;
					OP_XORI:  id_d.alu_op = ALU_XOR;
					default:  id_d.alu_op = ALU_ADD;
				endcase
			end
			OP_LUI: begin
				id_d.we  = 1'b1;
				id_d.lui = 1'b1;
			end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
				id_d.we        = 1'b1;
				id_d.use_imm   = 1'b1;
				id_d.sign_ext  = 1'b1;
				id_d.load      = 1'b1;
				id_d.wb_sel    = WB_LOAD;
				id_d.ld_signed = opcode inside {OP_LB, OP_LH};
				id_d.size = (opcode inside {OP_LB, OP_LBU}) ? SZ_BYTE :
					(opcode inside {OP_LH, OP_LHU}) ? SZ_HALF : SZ_WORD;
			end
			OP_SB, OP_SH, OP_SW: begin
				id_d.use_imm  = 1'b1;
				id_d.sign_ext = 1'b1;
				id_d.store    = 1'b1;
				id_d.size = (opcode == OP_SB) ? SZ_BYTE :
					(opcode == OP_SH) ? SZ_HALF : SZ_WORD;
			end
			OP_BEQ: is_beq = 1'b1;
			OP_BNE: is_bne = 1'b1;
			OP_J:   is_jump = 1'b1;
			OP_JAL: begin
				is_jump     = 1'b1;
				id_d.we     = 1'b1;
				id_d.dest   = LINK_REG;
				id_d.wb_sel = WB_LINK;
			end
			default: ;  // undefined opcodes fall through as nops
		endcase
		if (stall) begin  // bubble into EX
			id_d.we    = 1'b0;
			id_d.load  = 1'b0;
			id_d.store = 1'b0;
		end
	end

	// branches compare forwarded operands
	always_comb begin
		redirect = is_jump | is_jr | (is_beq & (rs_val == rt_val)) |
			(is_bne & (rs_val != rt_val));
		if (is_jr)
			redirect_pc = rs_val;
		else if (is_jump)
			redirect_pc = {pc_plus4[31:28], if_inst[25:0], 2'b00};
		else
			redirect_pc = pc_plus4 + {{14{if_inst[15]}}, if_inst[15:0], 2'b00};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex.we    <= 1'b0;
			id_ex.load  <= 1'b0;
			id_ex.store <= 1'b0;
		end else begin
			id_ex <= id_d;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/hazard_unit.sv ====
`default_nettype none

module hazard_unit import mips_pkg::*; (
	input  wire reg_addr_t rs_addr,
	input  wire reg_addr_t rt_addr,
	input  wire word_t     rs_raw,
	input  wire word_t     rt_raw,
	bypass_if.hazard       byp,
	output word_t          rs_val,
	output word_t          rt_val,
	output logic           stall
);

	// youngest result wins
	function automatic word_t forward(input reg_addr_t addr, input word_t raw);
		if (byp.ex_we && byp.ex_dest != '0 && byp.ex_dest == addr)
			return byp.ex_result;
		if (byp.mem_we && byp.mem_dest != '0 && byp.mem_dest == addr)
			return byp.mem_data;
		return raw;
	endfunction

	always_comb begin
		rs_val = forward(rs_addr, rs_raw);
		rt_val = forward(rt_addr, rt_raw);
	end

	// load data only exists once the load reaches MEM
	assign stall = byp.ex_load && byp.ex_we && byp.ex_dest != '0 &&
		(byp.ex_dest == rs_addr || byp.ex_dest == rt_addr);

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`default_nettype none

module execute_stage import mips_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire id_ex_t id_ex,
	bypass_if.ex_src    byp,
	output ex_mem_t     ex_mem
);

	word_t op_a, op_b, alu_res, result;

	assign op_a = id_ex.rs_val;
	assign op_b = !id_ex.use_imm ? id_ex.rt_val :
		id_ex.sign_ext ? {{16{id_ex.imm[15]}}, id_ex.imm} : {16'h0, id_ex.imm};

	always_comb begin
		case (id_ex.alu_op)
			ALU_ADD:  alu_res = op_a + op_b;
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_AND:  alu_res = op_a & op_b;
			ALU_OR:   alu_res = op_a | op_b;
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_NOR:  alu_res = ~(op_a | op_b);
			ALU_SLT:  alu_res = {31'h0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_res = {31'h0, op_a < op_b};
			ALU_SLL:  alu_res = op_b << id_ex.shamt;  // shifts act on rt
			ALU_SRL:  alu_res = op_b >> id_ex.shamt;
			ALU_SRA:  alu_res = word_t'($signed(op_b) >>> id_ex.shamt);
			default:  alu_res = '0;
		endcase
	end

	assign result = (id_ex.wb_sel == WB_LINK) ? id_ex.link :
		id_ex.lui ? {id_ex.imm, 16'h0} : alu_res;

	assign byp.ex_dest   = id_ex.dest;
	assign byp.ex_we     = id_ex.we;
	assign byp.ex_load   = id_ex.load;
	assign byp.ex_result = result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem.we    <= 1'b0;
			ex_mem.load  <= 1'b0;
			ex_mem.store <= 1'b0;
		end else begin
			ex_mem.result    <= result;
			ex_mem.st_data   <= id_ex.rt_val;
			ex_mem.st_reg    <= id_ex.st_reg;
			ex_mem.dest      <= id_ex.dest;
			ex_mem.we        <= id_ex.we;
			ex_mem.load      <= id_ex.load;
			ex_mem.store     <= id_ex.store;
			ex_mem.size      <= id_ex.size;
			ex_mem.ld_signed <= id_ex.ld_signed;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mem_stage.sv ====
`default_nettype none

module mem_stage import mips_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire ex_mem_t ex_mem,
	input  wire word_t   mem_rdata,
	bypass_if.mem_src    byp,
	output word_t        mem_addr,
	output word_t        mem_wdata,
	output byte_en_t     mem_we,
	output logic         mem_rd,
	output mem_wb_t      mem_wb
);

	logic [1:0] off;
	word_t      st_data, rd_shift, ld_val, wb_data;
	logic [15:0] ld_half;

	assign off      = ex_mem.result[1:0];
	assign mem_addr = {ex_mem.result[31:2], 2'b00};
	assign mem_rd   = ex_mem.load;

	// rt may still be sitting in WB
	assign st_data = (mem_wb.we && mem_wb.dest != '0 && mem_wb.dest == ex_mem.st_reg) ?
		mem_wb.data : ex_mem.st_data;

	////////////////////////////////////////////////////////////
	// store lanes
	always_comb begin
		mem_wdata = st_data;
		mem_we    = '0;
		case (ex_mem.size)
			SZ_BYTE: begin
				mem_wdata = {24'h0, st_data[7:0]} << {off, 3'b000};
				mem_we    = byte_en_t'(4'b0001 << off);
			end
			SZ_HALF: begin
				mem_wdata = {16'h0, st_data[15:0]} << {off, 3'b000};
				mem_we    = (off == 2'd0) ? 4'b0011 : (off == 2'd2) ? 4'b1100 : 4'b0000;
			end
			default: mem_we = (off == 2'd0) ? 4'b1111 : 4'b0000;
		endcase
		if (!ex_mem.store)
			mem_we = '0;
	end

	////////////////////////////////////////////////////////////
	// load extract and extend
	assign rd_shift = mem_rdata >> {off, 3'b000};
	assign ld_half  = off[1] ? mem_rdata[31:16] : mem_rdata[15:0];

	always_comb begin
		case (ex_mem.size)
			SZ_BYTE: ld_val = {{24{ex_mem.ld_signed & rd_shift[7]}}, rd_shift[7:0]};
			SZ_HALF: ld_val = {{16{ex_mem.ld_signed & ld_half[15]}}, ld_half};
			default: ld_val = mem_rdata;
		endcase
	end

	assign wb_data = ex_mem.load ? ld_val : ex_mem.result;

	assign byp.mem_dest = ex_mem.dest;
	assign byp.mem_we   = ex_mem.we;
	assign byp.mem_data = wb_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb.we <= 1'b0;
		end else begin
			mem_wb.we   <= ex_mem.we;
			mem_wb.dest <= ex_mem.dest;
			mem_wb.data <= wb_data;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mips_core.sv ====
`default_nettype none

module mips_core import mips_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire word_t inst_data,
	input  wire word_t mem_rdata,
	output word_t      inst_addr,
	output word_t      mem_addr,
	output word_t      mem_wdata,
	output byte_en_t   mem_we,
	output logic       mem_rd
);

	logic      stall;
	logic      redirect;
	word_t     redirect_pc;
	word_t     if_inst, if_pc;
	reg_addr_t rs_addr, rt_addr;
	word_t     rs_raw, rt_raw;   // register file, write-through only
	word_t     rs_val, rt_val;   // after forwarding
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;
	mem_wb_t   mem_wb;

	bypass_if byp ();

	fetch_unit u_fetch (
		.clk, .rst_n, .stall, .redirect, .redirect_pc, .inst_data,
		.inst_addr, .if_inst, .if_pc
	);

	decode_stage u_decode (
		.clk, .rst_n, .if_inst, .if_pc, .stall, .rs_val, .rt_val, .mem_wb,
		.rs_addr, .rt_addr, .rs_raw, .rt_raw, .redirect, .redirect_pc, .id_ex
	);

	hazard_unit u_hazard (
		.rs_addr, .rt_addr, .rs_raw, .rt_raw,
		.byp     (byp.hazard),
		.rs_val, .rt_val, .stall
	);

	execute_stage u_execute (
		.clk, .rst_n, .id_ex,
		.byp     (byp.ex_src),
		.ex_mem
	);

	mem_stage u_mem (
		.clk, .rst_n, .ex_mem, .mem_rdata,
		.byp     (byp.mem_src),
		.mem_addr, .mem_wdata, .mem_we, .mem_rd, .mem_wb
	);

endmodule

`default_nettype wire

// ==== bench/store_checker.sv ====
`default_nettype none

module store_checker import mips_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire word_t    inst_addr,
	input  wire word_t    mem_addr,
	input  wire word_t    mem_wdata,
	input  wire byte_en_t mem_we,
	input  wire logic     mem_rd,
	output logic          done,
	output int            errors,
	output int            seen
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_STORES = 32;

	word_t    exp_addr [MAX_STORES];
	byte_en_t exp_be   [MAX_STORES];
	word_t    exp_data [MAX_STORES];
	int       n_exp;

	function automatic word_t lane_mask(input byte_en_t be);
		return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
	endfunction

	initial begin
		int    fd;
		string line;
		word_t a, d;
		byte_en_t be;
		errors = 0;
		seen   = 0;
		n_exp  = 0;
		fd = $fopen("bench/core_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file for expected stores");
			errors++;
		end else begin
			while (!$feof(fd) && n_exp < MAX_STORES) begin
				if ($fgets(line, fd) == 0)
					break;
				if ($sscanf(line, "S %h %h %h", a, be, d) == 3) begin
					exp_addr[n_exp] = a;
					exp_be[n_exp]   = be;
					exp_data[n_exp] = d;
					n_exp++;
				end
			end
			$fclose(fd);
		end
	end

	assign done = (n_exp > 0) && (seen == n_exp);

	// first fetch still at the reset vector
	always @(posedge rst_n) begin
		#1;
		if (inst_addr != RESET_PC) begin
			$display("MISMATCH %0t inst_addr exp %h got %h", $time, RESET_PC, inst_addr);
			errors++;
		end
	end

	////////////////////////////////////////////////////////////
	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst_n) begin
			if (inst_addr != RESET_PC) begin
				$display("MISMATCH %0t inst_addr exp %h got %h", $time, RESET_PC, inst_addr);
				errors++;
			end
			if (mem_we != '0) begin
				$display("MISMATCH %0t mem_we exp %h got %h", $time, 4'h0, mem_we);
				errors++;
			end
			if (mem_rd != 1'b0) begin
				$display("MISMATCH %0t mem_rd exp %b got %b", $time, 1'b0, mem_rd);
				errors++;
			end
		end else begin
			// a store in MEM is never a load as well
			if (mem_rd && mem_we != '0) begin
				$display("MISMATCH %0t mem_rd exp %b got %b", $time, 1'b0, mem_rd);
				errors++;
			end
			if (mem_we != '0) begin
				if (seen >= n_exp) begin
					$display("unexpected store at %0t to address %h", $time, mem_addr);
					errors++;
				end else begin
					if (mem_addr != exp_addr[seen]) begin
						$display("MISMATCH %0t mem_addr exp %h got %h", $time,
							exp_addr[seen], mem_addr);
						errors++;
					end
					if (mem_we != exp_be[seen]) begin
						$display("MISMATCH %0t mem_we exp %h got %h", $time,
							exp_be[seen], mem_we);
						errors++;
					end
					// only enabled lanes carry data
					if ((mem_wdata & lane_mask(exp_be[seen])) !=
						(exp_data[seen] & lane_mask(exp_be[seen]))) begin
						$display("MISMATCH %0t mem_wdata exp %h got %h", $time,
							exp_data[seen], mem_wdata);
						errors++;
					end
					seen++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_mips_core.sv ====
`default_nettype none

module tb_mips_core import mips_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_CYCLES = 2000;
	localparam int DRAIN_CYCLES = 20;  // catches stray stores after the last one

	logic     clk, rst_n;
	word_t    inst_data, mem_rdata;
	word_t    inst_addr, mem_addr, mem_wdata;
	byte_en_t mem_we;
	logic     mem_rd;
	logic     done;
	int       chk_errors, seen, bench_errors;

	word_t imem [64];
	word_t dmem [128];

	mips_core dut (
		.clk, .rst_n, .inst_data, .mem_rdata,
		.inst_addr, .mem_addr, .mem_wdata, .mem_we, .mem_rd
	);

	store_checker u_checker (
		.clk, .rst_n, .inst_addr, .mem_addr, .mem_wdata, .mem_we, .mem_rd,
		.done, .errors (chk_errors), .seen
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic load_program();
		int    fd;
		string line;
		word_t a, w;
		fd = $fopen("bench/core_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file for the program");
			bench_errors++;
			return;
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) == 0)
				break;
			if ($sscanf(line, "I %h %h", a, w) == 2 && a < 32'd256)
				imem[a[7:2]] = w;
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////
	// memory models
	always @(negedge clk) begin
		// stores land before the next read
		if (rst_n && mem_we != '0 && mem_addr < 32'd512) begin
			for (int b = 0; b < 4; b++)
				if (mem_we[b])
					dmem[mem_addr[8:2]][b*8 +: 8] = mem_wdata[b*8 +: 8];
		end
		mem_rdata <= (mem_rd && mem_addr < 32'd512) ? dmem[mem_addr[8:2]] : '0;
		inst_data <= (inst_addr < 32'd256) ? imem[inst_addr[7:2]] : NOP_WORD;
	end

	initial begin
		int cycles;
		rst_n        = 1'b0;
		inst_data    = NOP_WORD;
		mem_rdata    = '0;
		bench_errors = 0;
		for (int i = 0; i < 64; i++)
			imem[i] = NOP_WORD;
		for (int i = 0; i < 128; i++)
			dmem[i] = 32'h5a00_0000 ^ ~(word_t'(i) << 2);  // address-dependent fill
		load_program();

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;

		cycles = 0;
		while (!done && cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout waiting for stores, %0d seen", seen);
			bench_errors++;
		end else begin
			cycles = 0;
			while (cycles < DRAIN_CYCLES) begin
				@(posedge clk);
				cycles++;
			end
		end

		@(posedge clk);
		$display("errors: checker %0d, bench %0d, stores seen %0d",
			chk_errors, bench_errors, seen);
		if (chk_errors == 0 && bench_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mini_mips.f ====
verilog/mips_pkg.sv
verilog/bypass_if.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/mips_core.sv
bench/store_checker.sv
bench/tb_mips_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f mini_mips.f --top-module tb_mips_core -o sim_mini_mips
out=$(./obj_dir/sim_mini_mips)
echo "$out"
echo "$out" | grep -q "^Verification passed$"

// ==== bench/core_trace.txt ====
# I <pc> <instruction word>
# S <word address> <byte enables> <data>, expected stores in program order
I 00000000 3c011234
I 00000004 34215678
I 00000008 2402fffd
I 0000000c 00411823
I 00000010 00032103
I 00000014 ac040100
I 00000018 8c050100
I 0000001c 00a13021
I 00000020 a0060105
I 00000024 a401010a
I 00000028 80070101
I 0000002c 94080102
I 00000030 00e84826
I 00000034 ac09010c
I 00000038 840a0100
I 0000003c 900b0103
I 00000040 014b6021
I 00000044 ac0c0110
I 00000048 10210002
I 0000004c 240d0007
I 00000050 ac0101f0
I 00000054 14210002
I 00000058 25ad0001
I 0000005c 0c00001c
I 00000060 ac0d0114
I 00000064 ac0e011c
I 00000068 0800001a
I 0000006c 00000000
I 00000070 ac1f0118
I 00000074 03e00008
I 00000078 240e0055
S 00000100 f fedcba98
S 00000104 2 00001000
S 00000108 c 56780000
S 0000010c f ffff0166
S 00000110 f ffffbb96
S 00000114 f 00000008
S 00000118 f 00000064
S 0000011c f 00000055
